//--- compile.f
+incdir+include
logic/lsu_pkg.sv
logic/load_addr_stage.sv
logic/load_data_stage.sv
logic/store_queue.sv
logic/data_memory.sv
logic/load_buffer.sv
logic/load_unit.sv
tests/load_unit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = load_unit_tb
FILELIST  = compile.f
BUILD     = obj_dir
LOG       = sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: sim clean

//--- include/lsu_tb_defs.svh
`ifndef lsu_tb_defs_svh
`define lsu_tb_defs_svh

// ----------------------------------------------------------
// run length
// ----------------------------------------------------------
`define tb_num_ops        600     // random operations per run
`define tb_timeout_margin 200     // cycles on top of ops times 8

// initial value of the seed variable
`define tb_seed           61

// ----------------------------------------------------------
// stimulus mix, percent per cycle
// ----------------------------------------------------------
`define tb_load_pct       45
`define tb_store_pct      25
`define tb_retire_pct     30

// bytes of address space the stimulus touches, 16 blocks of 8 bytes
`define tb_addr_span      128

// reset length in clock cycles
`define tb_reset_cycles   4

`endif

//--- tests/load_unit_tb.sv
`timescale 1ns/10ps
`include "lsu_tb_defs.svh"

module load_unit_tb
    import lsu_pkg::*;
();

    logic clock, reset, load_req, load_ready, store_req, store_retire;
    logic [xlen-1:0] load_base, load_offset, wb_data;
    load_func_t load_func;
    reg_idx_t load_dest, wb_dest;
    mem_addr_t store_addr;
    data_word_t store_data;
    byte_mask_t store_mask;
    sq_idx_t store_count;
    logic wb_valid, wb_miss;

    integer seed = `tb_seed;
    int errors = 0;
    int loads_checked = 0;
    int loads_issued = 0;
    int cycle_count = 0;
    int stores_inserted = 0;  // store sequence numbers, oldest retires first
    int stores_retired = 0;

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    logic [7:0] mem_bytes [`tb_addr_span];
    logic mem_valid [`tb_addr_span];
    logic [31:0] sq_addr [$];
    logic [31:0] sq_data [$];
    logic [3:0] sq_mask [$];
    logic [31:0] exp_data [$];
    logic exp_miss [$];
    logic [4:0] exp_dest [$];
    int exp_tail [$];   // stores older than each pending load

    load_unit i_load_unit (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > `tb_num_ops * 8 + `tb_timeout_margin) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic int pick_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // memory bytes overlaid by queued stores in age order, then aligned and extended
    task automatic predict_load(input logic [31:0] addr, input load_func_t func,
                                output logic [31:0] data, output logic miss);
        logic [31:0] word;
        logic [31:0] shifted;
        logic [7:0] byte_val;
        logic byte_ok;
        logic [6:0] idx;
        int off;
        int size;
        off = int'(addr[1:0]);
        size = (func == func_lw) ? 4 : ((func == func_lh || func == func_lhu) ? 2 : 1);
        word = '0;
        miss = 1'b0;
        for (int k = 0; k < 4; k++) begin
            idx = {addr[6:2], 2'b00} + 7'(k);
            byte_val = mem_bytes[idx];
            byte_ok = mem_valid[idx];
            for (int i = 0; i < sq_addr.size(); i++) begin
                if (sq_addr[i][31:2] == addr[31:2] && sq_mask[i][k]) begin
                    byte_val = sq_data[i][8*k +: 8];
                    byte_ok = 1'b1;
                end
            end
            if (k >= off && k < off + size) begin
                if (byte_ok)
                    word[8*k +: 8] = byte_val;
                else
                    miss = 1'b1;   // unsupplied bytes read as zero
            end
        end
        shifted = word >> (8 * off);
        case (func)
            func_lb:  data = {{24{shifted[7]}}, shifted[7:0]};
            func_lbu: data = {24'b0, shifted[7:0]};
            func_lh:  data = {{16{shifted[15]}}, shifted[15:0]};
            func_lhu: data = {16'b0, shifted[15:0]};
            default:  data = shifted;
        endcase
    endtask

    task automatic retire_model();
        logic [6:0] idx;
        for (int k = 0; k < 4; k++) begin
            idx = {sq_addr[0][6:2], 2'b00} + 7'(k);
            if (sq_mask[0][k]) begin
                mem_bytes[idx] = sq_data[0][8*k +: 8];
                mem_valid[idx] = 1'b1;
            end
        end
        void'(sq_addr.pop_front());
        void'(sq_data.pop_front());
        void'(sq_mask.pop_front());
        stores_retired++;
    endtask

    task automatic check_outputs();
        check_value("store_count", 32'(sq_addr.size()), 32'(store_count));
        if (wb_valid) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("writeback at %0d ns with no load outstanding", $time);
            end else begin
                check_value("wb_dest", 32'(exp_dest.pop_front()), 32'(wb_dest));
                check_value("wb_miss", 32'(exp_miss.pop_front()), 32'(wb_miss));
                check_value("wb_data", exp_data.pop_front(), wb_data);
                void'(exp_tail.pop_front());
                loads_checked++;
            end
        end
    endtask

    // one clock of stimulus with stores and retire at +2 ns and the load at +3 ns
    task automatic run_cycle(input bit issue);
        logic [31:0] addr, st_addr, st_data, data;
        logic [3:0] st_mask;
        logic st_new, miss, can_retire;
        logic ready_exp;
        load_func_t func;
        @(posedge clock);
        #2;
        check_outputs();
        store_req = 1'b0;
        store_retire = 1'b0;
        load_req = 1'b0;
        st_new = 1'b0;
        if (issue) begin
            // a younger store must not reach memory before a pending load reads it
            can_retire = sq_addr.size() > 0 &&
                         (exp_tail.size() == 0 || stores_retired < exp_tail[0]);
            if (sq_addr.size() < sq_depth && pick_below(100) < `tb_store_pct) begin
                st_addr = 32'(pick_below(`tb_addr_span / 4)) << 2;
                st_data = $random(seed);
                st_mask = 4'(pick_below(15) + 1);
                store_req = 1'b1;
                store_addr.word = st_addr;
                store_data.word = st_data;
                store_mask = st_mask;
                st_new = 1'b1;
            end
            if (can_retire && pick_below(100) < `tb_retire_pct) begin
                store_retire = 1'b1;
                retire_model();
            end
            #1;
            // both stages hold a load and a retire stalls the data stage
            ready_exp = !(exp_data.size() == 2 && store_retire);
            check_value("load_ready", 32'(ready_exp), 32'(load_ready));
            if (load_ready && pick_below(100) < `tb_load_pct) begin
                case (pick_below(5))
                    0:       func = func_lb;
                    1:       func = func_lbu;
                    2:       func = func_lh;
                    3:       func = func_lhu;
                    default: func = func_lw;
                endcase
                if (st_new && pick_below(3) == 0)
                    addr = {st_addr[31:2], 2'(pick_below(4))};   // same-cycle store
                else if (sq_addr.size() > 0 && pick_below(2) == 0)
                    addr = {sq_addr[sq_addr.size()-1][31:2], 2'(pick_below(4))};
                else
                    addr = 32'(pick_below(`tb_addr_span));
                if (func == func_lh || func == func_lhu)
                    addr[0] = 1'b0;
                if (func == func_lw)
                    addr[1:0] = 2'b00;
                predict_load(addr, func, data, miss);
                exp_data.push_back(data);
                exp_miss.push_back(miss);
                exp_dest.push_back(5'(loads_issued));
                exp_tail.push_back(stores_inserted);
                load_req = 1'b1;
                load_func = func;
                load_offset = $random(seed);
                load_base = addr - load_offset;
                load_dest = 5'(loads_issued);
                loads_issued++;
            end
            if (st_new) begin
                sq_addr.push_back(st_addr);
                sq_data.push_back(st_data);
                sq_mask.push_back(st_mask);
                stores_inserted++;
            end
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        load_req = 1'b0;
        store_req = 1'b0;
        store_retire = 1'b0;
        repeat (`tb_reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int a = 0; a < `tb_addr_span; a++)
            mem_valid[a] = 1'b0;
        sq_addr.delete();
        sq_data.delete();
        sq_mask.delete();
        stores_inserted = 0;
        stores_retired = 0;
        check_value("wb_valid", 32'd0, 32'(wb_valid));
        check_value("load_ready", 32'd1, 32'(load_ready));
        check_value("store_count", 32'd0, 32'(store_count));
    endtask

    task automatic drain_loads();
        while (exp_data.size() > 0)
            run_cycle(1'b0);
    endtask

    initial begin
        clock = 1'b0;
        load_base = '0;
        load_offset = '0;
        load_func = func_lb;
        load_dest = '0;
        store_addr.word = '0;
        store_data.word = '0;
        store_mask = '0;
        apply_reset();
        repeat (`tb_num_ops / 2) run_cycle(1'b1);
        drain_loads();
        apply_reset();   // everything written so far must read as a miss now
        repeat (`tb_num_ops / 2) run_cycle(1'b1);
        drain_loads();
        $display("load_unit_tb: %0d errors, %0d loads checked", errors, loads_checked);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- logic/load_unit.sv
`timescale 1ns/10ps

module load_unit
    import lsu_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    // load request
    input  logic            load_req,
    input  logic [xlen-1:0] load_base,
    input  logic [xlen-1:0] load_offset,
    input  load_func_t      load_func,
    input  reg_idx_t        load_dest,
    output logic            load_ready,
    // store insert and retire
    input  logic            store_req,
    input  mem_addr_t       store_addr,
    input  data_word_t      store_data,
    input  byte_mask_t      store_mask,
    input  logic            store_retire,
    output sq_idx_t         store_count,
    // writeback
    output logic            wb_valid,
    output reg_idx_t        wb_dest,
    output logic [xlen-1:0] wb_data,
    output logic            wb_miss
);

    // ----------------------------------------------------------
    // stage to stage wiring
    // ----------------------------------------------------------
    logic       addr_valid, data_free;
    mem_addr_t  addr_addr;
    byte_mask_t addr_mask;
    load_func_t addr_func;
    reg_idx_t   addr_dest;
    sq_idx_t    addr_sq_tail, sq_tail, load_sq_tail;

    logic                             load_valid, load_accepted;
    mem_addr_t                        load_addr;
    data_word_t [words_per_block-1:0] mem_data;
    byte_mask_t [words_per_block-1:0] mem_mask;
    data_word_t                       fwd_data;
    byte_mask_t                       fwd_mask;

    logic       ret_valid;
    mem_addr_t  ret_addr;
    data_word_t ret_data;
    byte_mask_t ret_mask;

    logic       lb_valid;
    data_word_t lb_result;
    byte_mask_t lb_mask;
    mem_addr_t  lb_addr;
    load_func_t lb_func;
    reg_idx_t   lb_dest;

    load_addr_stage i_load_addr_stage (.*);
    load_data_stage i_load_data_stage (.*);
    store_queue     i_store_queue     (.*);
    data_memory     i_data_memory     (.*);
    load_buffer     i_load_buffer     (.*);

endmodule

//--- logic/load_buffer.sv
`timescale 1ns/10ps

module load_buffer
    import lsu_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    // from the data stage
    input  logic            lb_valid,
    input  logic            load_accepted,
    input  data_word_t      lb_result,
    input  byte_mask_t      lb_mask,    // bytes nobody supplied
    input  mem_addr_t       lb_addr,
    input  load_func_t      lb_func,
    input  reg_idx_t        lb_dest,
    // writeback
    output logic            wb_valid,
    output reg_idx_t        wb_dest,
    output logic [xlen-1:0] wb_data,
    output logic            wb_miss
);

    data_word_t      shifted;
    logic [xlen-1:0] extended;
    logic            take;

    assign take = lb_valid & load_accepted;

    // move the addressed bytes down to bit 0
    assign shifted.word = lb_result.word >> {lb_addr.fields.offset, 3'b000};

    always_comb begin
        case (lb_func)
            func_lb:  extended = {{24{shifted.bytes[0][7]}}, shifted.bytes[0]};
            func_lbu: extended = {24'b0, shifted.bytes[0]};
            func_lh:  extended = {{16{shifted.bytes[1][7]}}, shifted.bytes[1], shifted.bytes[0]};
            func_lhu: extended = {16'b0, shifted.bytes[1], shifted.bytes[0]};
            default:  extended = shifted.word;   // lw
        endcase
    end

    // ----------------------------------------------------------
    // writeback register
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= take;   // one cycle per load
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            wb_dest <= lb_dest;
            wb_data <= extended;        // partial value kept on a miss
            wb_miss <= |lb_mask;
        end
    end

endmodule

//--- logic/data_memory.sv
`timescale 1ns/10ps

module data_memory
    import lsu_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    // load read port
    input  logic                             load_valid,
    input  mem_addr_t                        load_addr,
    // retire write port
    input  logic                             ret_valid,
    input  mem_addr_t                        ret_addr,
    input  data_word_t                       ret_data,
    input  byte_mask_t                       ret_mask,
    // read result, whole block
    output data_word_t [words_per_block-1:0] mem_data,
    output byte_mask_t [words_per_block-1:0] mem_mask,
    output logic                             load_accepted
);

    data_word_t [words_per_block-1:0] blocks      [mem_blocks];
    byte_mask_t [words_per_block-1:0] byte_valid  [mem_blocks];

    // ----------------------------------------------------------
    // read side, combinational
    // ----------------------------------------------------------
    assign mem_data = blocks[load_addr.fields.block];

    // no valid bytes reported without a load
    assign mem_mask = load_valid ? byte_valid[load_addr.fields.block] : '0;

    // a retire owns the memory this cycle
    assign load_accepted = ~ret_valid;

    // ----------------------------------------------------------
    // write side
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (ret_valid) begin
            for (int b = 0; b < bytes_per_word; b++) begin
                if (ret_mask[b]) begin
                    blocks[ret_addr.fields.block][ret_addr.fields.w_idx].bytes[b] <=
                        ret_data.bytes[b];
                end
            end
        end
    end

    // valid bits only ever set until the next reset
    always_ff @(posedge clock) begin
        if (reset) begin
            byte_valid <= '{default: '0};
        end else if (ret_valid) begin
            byte_valid[ret_addr.fields.block][ret_addr.fields.w_idx] <=
                byte_valid[ret_addr.fields.block][ret_addr.fields.w_idx] | ret_mask;
        end
    end

endmodule

//--- logic/store_queue.sv
`timescale 1ns/10ps

module store_queue
    import lsu_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    // insert and retire strobes
    input  logic       store_req,
    input  mem_addr_t  store_addr,
    input  data_word_t store_data,
    input  byte_mask_t store_mask,
    input  logic       store_retire,
    // forwarding lookup from the data stage
    input  mem_addr_t  load_addr,
    input  sq_idx_t    load_sq_tail,
    output sq_idx_t    sq_tail,
    output sq_idx_t    store_count,
    output data_word_t fwd_data,
    output byte_mask_t fwd_mask,
    // write toward the memory
    output logic       ret_valid,
    output mem_addr_t  ret_addr,
    output data_word_t ret_data,
    output byte_mask_t ret_mask
);

    mem_addr_t  entry_addr [sq_depth];
    data_word_t entry_data [sq_depth];
    byte_mask_t entry_mask [sq_depth];

    sq_idx_t head;
    sq_idx_t tail;
    sq_idx_t span;   // entries older than the load

    assign sq_tail     = tail;
    assign store_count = tail - head;
    assign span        = load_sq_tail - head;

    // ----------------------------------------------------------
    // retire port, oldest entry first
    // ----------------------------------------------------------
    assign ret_valid = store_retire && (store_count != '0);
    assign ret_addr  = entry_addr[head[sq_ptr_bits-1:0]];
    assign ret_data  = entry_data[head[sq_ptr_bits-1:0]];
    assign ret_mask  = entry_mask[head[sq_ptr_bits-1:0]];

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (store_req) tail <= tail + 1'b1;
            if (ret_valid) head <= head + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (store_req) begin
            entry_addr[tail[sq_ptr_bits-1:0]] <= store_addr;
            entry_data[tail[sq_ptr_bits-1:0]] <= store_data;
            entry_mask[tail[sq_ptr_bits-1:0]] <= store_mask;
        end
    end

    // ----------------------------------------------------------
    // forwarding: walk head to load tail, younger stores overwrite
    // ----------------------------------------------------------
    always_comb begin
        logic [sq_ptr_bits-1:0] slot;
        fwd_data = '0;
        fwd_mask = '0;
        for (int i = 0; i < sq_depth; i++) begin
            slot = head[sq_ptr_bits-1:0] + sq_ptr_bits'(i);
            if (i < span && entry_addr[slot].word[xlen-1:2] == load_addr.word[xlen-1:2]) begin
                for (int b = 0; b < bytes_per_word; b++) begin
                    if (entry_mask[slot][b]) begin
                        fwd_data.bytes[b] = entry_data[slot].bytes[b];
                        fwd_mask[b]       = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- logic/load_data_stage.sv
`timescale 1ns/10ps

module load_data_stage
    import lsu_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    // ----------------------------------------------------------
    // from the address stage
    input  logic                             addr_valid,
    input  mem_addr_t                        addr_addr,
    input  byte_mask_t                       addr_mask,
    input  load_func_t                       addr_func,
    input  reg_idx_t                         addr_dest,
    input  sq_idx_t                          addr_sq_tail,
    output logic                             data_free,
    // ----------------------------------------------------------
    // memory and store queue
    input  logic                             load_accepted,
    input  data_word_t [words_per_block-1:0] mem_data,
    input  byte_mask_t [words_per_block-1:0] mem_mask,
    input  data_word_t                       fwd_data,
    input  byte_mask_t                       fwd_mask,
    output logic                             load_valid,
    output mem_addr_t                        load_addr,   // shared by memory and queue
    output sq_idx_t                          load_sq_tail,
    // ----------------------------------------------------------
    // to the load buffer
    output logic                             lb_valid,
    output data_word_t                       lb_result,
    output byte_mask_t                       lb_mask,
    output mem_addr_t                        lb_addr,
    output load_func_t                       lb_func,
    output reg_idx_t                         lb_dest
);

    logic       held_valid;
    mem_addr_t  held_addr;
    byte_mask_t held_mask;
    load_func_t held_func;
    reg_idx_t   held_dest;
    sq_idx_t    held_tail;

    // empty, or the held load leaves this cycle
    assign data_free = ~held_valid | load_accepted;

    assign load_valid   = held_valid;
    assign load_addr    = held_addr;
    assign load_sq_tail = held_tail;

    assign lb_valid = held_valid;
    assign lb_addr  = held_addr;
    assign lb_func  = held_func;
    assign lb_dest  = held_dest;

    // store queue bytes win over memory bytes
    always_comb begin
        lb_result = '0;
        lb_mask   = held_mask;
        for (int b = 0; b < bytes_per_word; b++) begin
            if (held_mask[b]) begin
                if (fwd_mask[b]) begin
                    lb_result.bytes[b] = fwd_data.bytes[b];
                    lb_mask[b]         = 1'b0;
                end else if (mem_mask[held_addr.fields.w_idx][b]) begin
                    lb_result.bytes[b] = mem_data[held_addr.fields.w_idx].bytes[b];
                    lb_mask[b]         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (data_free) begin
            held_valid <= addr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (data_free) begin
            held_addr <= addr_addr;
            held_mask <= addr_mask;
            held_func <= addr_func;
            held_dest <= addr_dest;
            held_tail <= addr_sq_tail;
        end
    end

endmodule

//--- logic/load_addr_stage.sv
`timescale 1ns/10ps

module load_addr_stage
    import lsu_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    // request from the pipeline
    input  logic             load_req,
    input  logic [xlen-1:0]  load_base,
    input  logic [xlen-1:0]  load_offset,
    input  load_func_t       load_func,
    input  reg_idx_t         load_dest,
    input  sq_idx_t          sq_tail,
    // stall from the data stage
    input  logic             data_free,
    output logic             load_ready,
    // to the data stage
    output logic             addr_valid,
    output mem_addr_t        addr_addr,
    output byte_mask_t       addr_mask,
    output load_func_t       addr_func,
    output reg_idx_t         addr_dest,
    output sq_idx_t          addr_sq_tail
);

    mem_addr_t  req_addr;
    byte_mask_t req_mask;

    assign req_addr.word = load_base + load_offset;

    // byte enables from size and byte offset, loads are aligned
    always_comb begin
        case (load_func)
            func_lb, func_lbu: req_mask = byte_mask_t'(4'b0001 << req_addr.fields.offset);
            func_lh, func_lhu: req_mask = byte_mask_t'(4'b0011 << req_addr.fields.offset);
            default:           req_mask = 4'b1111;
        endcase
    end

    // register can take a new request when empty or draining
    assign load_ready = data_free | ~addr_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            addr_valid <= 1'b0;
        end else if (load_ready) begin
            addr_valid <= load_req;
        end
    end

    always_ff @(posedge clock) begin
        if (load_ready && load_req) begin
            addr_addr    <= req_addr;
            addr_mask    <= req_mask;
            addr_func    <= load_func;
            addr_dest    <= load_dest;
            addr_sq_tail <= sq_tail;  // stores older than this load
        end
    end

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

    // ----------------------------------------------------------
    // widths and sizes
    // ----------------------------------------------------------
    localparam int xlen            = 32;
    localparam int bytes_per_word  = xlen / 8;
    localparam int words_per_block = 2;
    localparam int mem_blocks      = 16;
    localparam int block_bits      = $clog2(mem_blocks);
    localparam int sq_depth        = 4;
    localparam int sq_ptr_bits     = $clog2(sq_depth);

    typedef logic [bytes_per_word-1:0] byte_mask_t;
    typedef logic [sq_ptr_bits:0]      sq_idx_t;    // msb is the wrap bit
    typedef logic [4:0]                reg_idx_t;

    // ----------------------------------------------------------
    // word and address views
    // ----------------------------------------------------------
    typedef union packed {
        logic [xlen-1:0]                 word;
        logic [bytes_per_word-1:0][7:0]  bytes;
    } data_word_t;

    typedef union packed {
        logic [xlen-1:0] word;
        struct packed {
            logic [xlen-block_bits-4:0] upper;   // not decoded by the memory
            logic [block_bits-1:0]      block;
            logic                       w_idx;   // word within the block
            logic [1:0]                 offset;  // byte within the word
        } fields;
    } mem_addr_t;

    // load function codes, bit 2 marks unsigned
    typedef enum logic [2:0] {
        func_lb  = 3'b000,
        func_lh  = 3'b001,
        func_lw  = 3'b010,
        func_lbu = 3'b100,
        func_lhu = 3'b101
    } load_func_t;

endpackage
